//--- async_fifo.f
+incdir+logic
logic/fifo_word_pkg.sv
logic/fifo_ptr_pkg.sv
logic/dualport_ram.sv
logic/wr_ptr_ctrl.sv
logic/rd_ptr_ctrl.sv
logic/async_fifo.sv
tb/async_fifo_assertions.sv
tb/async_fifo_tb.sv

//--- logic/afifo_consts.svh
`ifndef AFIFO_CONSTS_SVH
`define AFIFO_CONSTS_SVH

// entries in the fifo, power of two.
`define AFIFO_DEPTH 16

// ram address width, log2 of the depth.
`define AFIFO_ADDR_W 4

// afull when the write side count reaches this.
`define AFIFO_AFULL_LVL 15

// aempty when the read side count drops to this.
`define AFIFO_AEMPTY_LVL 1

`endif

//--- logic/async_fifo.sv
`timescale 1ns/1ps

module async_fifo (
  input  logic                     wr_clk,
  input  logic                     wr_rst_n,
  input  logic                     wr_en,
  input  fifo_word_pkg::word_t     wr_data,
  input  logic                     rd_clk,
  input  logic                     rd_rst_n,
  input  logic                     rd_en,
  output fifo_word_pkg::word_t     rd_data,
  output fifo_ptr_pkg::wr_status_t wr_status,
  output fifo_ptr_pkg::rd_status_t rd_status
);

  import fifo_word_pkg::*;
  import fifo_ptr_pkg::*;

  logic  wr_accept;
  logic  rd_accept;
  addr_t wr_addr;
  addr_t rd_addr;
  ptr_t  wr_ptr_gray; // crosses to rd_clk.
  ptr_t  rd_ptr_gray; // crosses to wr_clk.

  dualport_ram #(
    .payload_t(word_t)
  ) u_ram (
    .wr_clk   (wr_clk),
    .wr_en    (wr_accept),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_accept),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  wr_ptr_ctrl u_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_accept   (wr_accept),
    .wr_addr     (wr_addr),
    .wr_ptr_gray (wr_ptr_gray),
    .wr_status   (wr_status)
  );

  rd_ptr_ctrl u_rd_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_gray (wr_ptr_gray),
    .rd_accept   (rd_accept),
    .rd_addr     (rd_addr),
    .rd_ptr_gray (rd_ptr_gray),
    .rd_status   (rd_status)
  );

endmodule

//--- logic/dualport_ram.sv
`timescale 1ns/1ps
`include "afifo_consts.svh"

module dualport_ram #(
  parameter type payload_t = fifo_word_pkg::word_t
) (
  input  logic                wr_clk,
  input  logic                wr_en,
  input  fifo_ptr_pkg::addr_t wr_addr,
  input  payload_t            wr_data,
  input  logic                rd_clk,
  input  logic                rd_rst_n,
  input  logic                rd_en,
  input  fifo_ptr_pkg::addr_t rd_addr,
  output payload_t            rd_data
);

  payload_t mem [`AFIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read word is valid one rd_clk after the accepted read.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- logic/fifo_ptr_pkg.sv
`include "afifo_consts.svh"

package fifo_ptr_pkg;

  typedef logic [`AFIFO_ADDR_W-1:0] addr_t;

  // extra msb tells a full fifo from an empty one.
  typedef logic [`AFIFO_ADDR_W:0] ptr_t;

  typedef struct packed {
    logic full;
    logic afull;
  } wr_status_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_status_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[$bits(ptr_t)-1] = gray[$bits(ptr_t)-1];
    for (int i = $bits(ptr_t) - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i]; // running xor from the msb down.
    end
    return bin;
  endfunction

endpackage

//--- logic/fifo_word_pkg.sv
package fifo_word_pkg;

  // tagged sample word carried from the write to the read domain.
  typedef struct packed {
    logic        last; // end of packet.
    logic [2:0]  tag;  // channel id.
    logic [11:0] data; // sample.
  } word_t;

endpackage

//--- logic/rd_ptr_ctrl.sv
`timescale 1ns/1ps
`include "afifo_consts.svh"

module rd_ptr_ctrl (
  input  logic                     rd_clk,
  input  logic                     rd_rst_n,
  input  logic                     rd_en,
  input  fifo_ptr_pkg::ptr_t       wr_ptr_gray,
  output logic                     rd_accept,
  output fifo_ptr_pkg::addr_t      rd_addr,
  output fifo_ptr_pkg::ptr_t       rd_ptr_gray,
  output fifo_ptr_pkg::rd_status_t rd_status
);

  import fifo_ptr_pkg::*;

  ptr_t rd_ptr_bin;
  ptr_t rd_ptr_nxt;
  ptr_t rd_gray_nxt;
  ptr_t wr_gray_s1;
  ptr_t wr_gray_s2;
  ptr_t wr_ptr_sync;
  ptr_t rd_count_nxt;

  assign rd_accept = rd_en && !rd_status.empty; // ignored while empty.
  assign rd_ptr_nxt = rd_ptr_bin + ptr_t'(rd_accept);
  assign rd_addr = addr_t'(rd_ptr_bin);
  assign rd_gray_nxt = bin2gray(rd_ptr_nxt);

  assign wr_ptr_sync = gray2bin(wr_gray_s2);
  // stale write pointer can only understate the count.
  assign rd_count_nxt = wr_ptr_sync - rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr_bin <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr_bin <= rd_ptr_nxt;
      rd_ptr_gray <= rd_gray_nxt;
    end
  end

  // two flop synchronizer for the write pointer.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_ptr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_status.empty <= 1'b1;
      rd_status.aempty <= 1'b1; // nothing stored out of reset.
    end else begin
      rd_status.empty <= (rd_ptr_nxt == wr_ptr_sync);
      rd_status.aempty <= (rd_count_nxt <= ptr_t'(`AFIFO_AEMPTY_LVL));
    end
  end

endmodule

//--- logic/wr_ptr_ctrl.sv
`timescale 1ns/1ps
`include "afifo_consts.svh"

module wr_ptr_ctrl (
  input  logic                     wr_clk,
  input  logic                     wr_rst_n,
  input  logic                     wr_en,
  input  fifo_ptr_pkg::ptr_t       rd_ptr_gray,
  output logic                     wr_accept,
  output fifo_ptr_pkg::addr_t      wr_addr,
  output fifo_ptr_pkg::ptr_t       wr_ptr_gray,
  output fifo_ptr_pkg::wr_status_t wr_status
);

  import fifo_ptr_pkg::*;

  ptr_t wr_ptr_bin;
  ptr_t wr_ptr_nxt;
  ptr_t wr_gray_nxt;
  ptr_t rd_gray_s1;
  ptr_t rd_gray_s2;
  ptr_t rd_ptr_sync;
  ptr_t wr_count_nxt;
  ptr_t full_match;

  assign wr_accept = wr_en && !wr_status.full; // dropped while full.
  assign wr_ptr_nxt = wr_ptr_bin + ptr_t'(wr_accept);
  assign wr_addr = addr_t'(wr_ptr_bin);
  assign wr_gray_nxt = bin2gray(wr_ptr_nxt);

  assign rd_ptr_sync = gray2bin(rd_gray_s2);
  // stale read pointer can only overstate the count.
  assign wr_count_nxt = wr_ptr_nxt - rd_ptr_sync;
  assign full_match = {~rd_ptr_sync[`AFIFO_ADDR_W], rd_ptr_sync[`AFIFO_ADDR_W-1:0]};

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr_bin <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr_bin <= wr_ptr_nxt;
      wr_ptr_gray <= wr_gray_nxt; // registered, one bit change per edge.
    end
  end

  // two flop synchronizer for the read pointer.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_ptr_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_status <= '0;
    end else begin
      wr_status.full <= (wr_ptr_nxt == full_match);
      wr_status.afull <= (wr_count_nxt >= ptr_t'(`AFIFO_AFULL_LVL));
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the async_fifo testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --top-module async_fifo_tb \
  -f async_fifo.f \
  -o sim_async_fifo

./obj_dir/sim_async_fifo 2>&1 | tee "$LOG"

if grep -q "sim failed" "$LOG"; then
  echo "failure reported, see $LOG"
  exit 1
fi

echo "no failure reported in $LOG"
exit 0

//--- tb/async_fifo_assertions.sv
`timescale 1ns/1ps

module async_fifo_assertions (
  input logic                     wr_clk,
  input logic                     wr_rst_n,
  input logic                     rd_clk,
  input logic                     rd_rst_n,
  input fifo_ptr_pkg::ptr_t       wr_ptr_gray,
  input fifo_ptr_pkg::ptr_t       rd_ptr_gray,
  input fifo_ptr_pkg::wr_status_t wr_status,
  input fifo_ptr_pkg::rd_status_t rd_status
);

  import fifo_ptr_pkg::*;

  function automatic logic gray_step_ok(input ptr_t prev, input ptr_t curr);
    return $countones(prev ^ curr) <= 1; // zero or one bit flips.
  endfunction

  wr_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    gray_step_ok($past(wr_ptr_gray), wr_ptr_gray))
    else $error("write gray pointer changed more than one bit in one edge");

  rd_gray_step: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    gray_step_ok($past(rd_ptr_gray), rd_ptr_gray))
    else $error("read gray pointer changed more than one bit in one edge");

  wr_hold_on_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_status.full |=> $stable(wr_ptr_gray))
    else $error("write pointer moved while the fifo was full");

  rd_hold_on_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_status.empty |=> $stable(rd_ptr_gray))
    else $error("read pointer moved while the fifo was empty");

  full_has_afull: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_status.full |-> wr_status.afull)
    else $error("full is set without afull");

  empty_has_aempty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_status.empty |-> rd_status.aempty)
    else $error("empty is set without aempty");

endmodule

bind async_fifo async_fifo_assertions u_fifo_assertions (
  .wr_clk      (wr_clk),
  .wr_rst_n    (wr_rst_n),
  .rd_clk      (rd_clk),
  .rd_rst_n    (rd_rst_n),
  .wr_ptr_gray (wr_ptr_gray),
  .rd_ptr_gray (rd_ptr_gray),
  .wr_status   (wr_status),
  .rd_status   (rd_status)
);

//--- tb/async_fifo_tb.sv
`timescale 1ns/1ps
`include "afifo_consts.svh"

module async_fifo_tb;

  import fifo_word_pkg::*;
  import fifo_ptr_pkg::*;

  typedef struct packed {
    wr_status_t wr;
    rd_status_t rd;
  } flag_set_t;

  localparam int WR_HALF = 20;
  localparam int RD_HALF = 28;
  // rough rd_clk cycles used by all tests.
  localparam int TEST_RD_CYCLES = 40 * 8 + 20 * 3 + 40 + 6 * 30 + 500 + 100;
  localparam int WATCHDOG_NS = 3 * TEST_RD_CYCLES * 2 * RD_HALF;

  logic       wr_clk;
  logic       wr_rst_n;
  logic       wr_en;
  word_t      wr_data;
  logic       rd_clk;
  logic       rd_rst_n;
  logic       rd_en;
  word_t      rd_data;
  wr_status_t wr_status;
  rd_status_t rd_status;

  word_t     exp_q[$];
  string     test_name;
  logic      rd_pending;
  logic      writing;
  flag_set_t exp_flags;
  int        fill_levels[6] = '{0, 1, 2, 14, 15, 16};

  async_fifo u_async_fifo (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .wr_status (wr_status),
    .rd_status (rd_status)
  );

  always #WR_HALF wr_clk = ~wr_clk;
  always #RD_HALF rd_clk = ~rd_clk; // unrelated to wr_clk.

  task automatic stop_with_failure();
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_wr_status(input string name, input wr_status_t expected,
                                 input wr_status_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %b actual %b", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_rd_status(input string name, input rd_status_t expected,
                                 input rd_status_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %b actual %b", name, expected, actual);
      stop_with_failure();
    end
  endtask

  function automatic word_t pop_expected();
    word_t w;
    w = exp_q.pop_front(); // oldest accepted write.
    return w;
  endfunction

  function automatic flag_set_t flags_expected(input int count);
    flag_set_t f;
    f.wr.full = (count >= `AFIFO_DEPTH);
    f.wr.afull = (count >= `AFIFO_AFULL_LVL);
    f.rd.empty = (count == 0);
    f.rd.aempty = (count <= `AFIFO_AEMPTY_LVL);
    return f;
  endfunction

  function automatic word_t random_word();
    return word_t'(16'($urandom));
  endfunction

  // words dropped while full still count as sent.
  task automatic write_words(input int n, input int gap_max);
    int sent;
    sent = 0;
    while (sent < n) begin
      @(posedge wr_clk);
      if (wr_en) sent++;
      if (sent < n && $urandom_range(gap_max, 0) == 0) begin
        wr_en <= 1'b1;
        wr_data <= random_word();
      end else begin
        wr_en <= 1'b0;
      end
    end
  endtask

  task automatic write_random(input int cycles, input int pct);
    repeat (cycles) begin
      @(posedge wr_clk);
      wr_en <= ($urandom_range(99, 0) < pct);
      wr_data <= random_word();
    end
    @(posedge wr_clk);
    wr_en <= 1'b0;
  endtask

  task automatic read_until_drained(input int pct);
    while (writing || exp_q.size() != 0) begin
      @(posedge rd_clk);
      rd_en <= ($urandom_range(99, 0) < pct);
    end
    rd_en <= 1'b0;
    repeat (2) @(posedge rd_clk);
  endtask

  task automatic settle();
    repeat (6) @(posedge wr_clk);
    repeat (6) @(posedge rd_clk);
  endtask

  task automatic check_flags(input string name, input int count);
    exp_flags = flags_expected(count);
    @(posedge wr_clk);
    check_wr_status(name, exp_flags.wr, wr_status);
    @(posedge rd_clk);
    check_rd_status(name, exp_flags.rd, rd_status);
  endtask

  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !wr_status.full) exp_q.push_back(wr_data);
  end

  always @(posedge rd_clk) begin : compare_reads
    logic was_pending;
    was_pending = rd_pending;
    rd_pending = rd_rst_n && rd_en && !rd_status.empty; // data shows next edge.
    if (was_pending) begin
      if (exp_q.size() == 0) begin
        $display("%s: a word was read that had never been written", test_name);
        stop_with_failure();
      end else begin
        check_word(test_name, pop_expected(), rd_data);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
    stop_with_failure();
  end

  initial begin
    void'($urandom(32'hc213));
    wr_clk = 1'b0;
    rd_clk = 1'b0;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en = 1'b0;
    wr_data = '0;
    rd_en = 1'b0;
    rd_pending = 1'b0;
    writing = 1'b0;
    test_name = "reset state";
    repeat (16) @(posedge wr_clk);
    wr_rst_n <= 1'b1;
    @(posedge rd_clk);
    rd_rst_n <= 1'b1;

    settle();
    check_flags("reset state", 0);
    check_word("reset state", word_t'(16'h0000), rd_data);

    test_name = "ordered transfer";
    writing = 1'b1;
    fork
      begin
        write_words(40, 2);
        @(posedge wr_clk);
        writing = 1'b0;
      end
      read_until_drained(50);
    join
    settle();

    test_name = "overflow";
    write_words(20, 0);
    settle();
    check_flags("overflow", `AFIFO_DEPTH);
    if (exp_q.size() != `AFIFO_DEPTH) begin
      $display("[FAIL] overflow expected %0d actual %0d", `AFIFO_DEPTH, exp_q.size());
      stop_with_failure();
    end
    read_until_drained(100);
    settle();
    check_flags("overflow drained", 0);

    test_name = "underflow";
    repeat (8) begin
      @(posedge rd_clk);
      rd_en <= 1'b1; // all ignored while empty.
    end
    @(posedge rd_clk);
    rd_en <= 1'b0;
    check_flags("underflow", 0);
    write_words(1, 0);
    settle();
    read_until_drained(100);
    repeat (8) begin
      @(posedge rd_clk);
      rd_en <= 1'b1;
    end
    @(posedge rd_clk);
    rd_en <= 1'b0;
    settle();
    check_flags("underflow after word", 0);

    test_name = "thresholds";
    for (int i = 0; i < 6; i++) begin
      if (fill_levels[i] > exp_q.size()) write_words(fill_levels[i] - exp_q.size(), 0);
      settle();
      check_flags($sformatf("thresholds at %0d", fill_levels[i]), fill_levels[i]);
    end
    read_until_drained(100);
    settle();

    test_name = "concurrent traffic";
    writing = 1'b1;
    fork
      begin
        write_random(500, 50);
        @(posedge wr_clk);
        writing = 1'b0;
      end
      read_until_drained(50);
    join
    settle();
    check_flags("concurrent traffic", 0);

    $display("sim passed");
    $finish;
  end

endmodule
